//--- mipsPipe_consts.svh
/*
 * widths, opcodes, function codes and ALU operation codes for the pipelined core
 */
`ifndef MIPS_PIPE_CONSTS_SVH
`define MIPS_PIPE_CONSTS_SVH

// data path and address width
`define MIPS_XLEN 32
// architectural registers, register 0 reads as zero
`define MIPS_NREGS 32

// primary opcodes, bits 31:26
`define MIPS_OP_RTYPE 6'b000000
`define MIPS_OP_LW    6'b100011
`define MIPS_OP_SW    6'b101011
`define MIPS_OP_BEQ   6'b000100
`define MIPS_OP_ADDI  6'b001000
`define MIPS_OP_J     6'b000010

// R-type function codes, bits 5:0
`define MIPS_FN_ADD 6'b100000
`define MIPS_FN_SUB 6'b100010
`define MIPS_FN_AND 6'b100100
`define MIPS_FN_OR  6'b100101
`define MIPS_FN_SLT 6'b101010

// ALU operations, bit 2 inverts operand b
`define MIPS_ALU_AND  3'b000
`define MIPS_ALU_OR   3'b001
`define MIPS_ALU_ADD  3'b010
`define MIPS_ALU_ANDN 3'b100
`define MIPS_ALU_ORN  3'b101
`define MIPS_ALU_SUB  3'b110
`define MIPS_ALU_SLT  3'b111

`endif

//--- mipsPkg.sv
/*
 * instruction union, control and hazard structs, memory request and pipeline registers
 */
`include "mipsPipe_consts.svh"

package mipsPkg;

	// the three instruction formats over one 32-bit word
	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rFields;

	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [15:0] imm;
	} iFields;

	typedef struct packed {
		logic [5:0] op;
		logic [25:0] target;
	} jFields;

	typedef union packed {
		rFields rFmt;
		iFields iFmt;
		jFields jFmt;
	} instrWord;

	typedef logic [2:0] aluCode;

	// operand source in execute
	typedef enum logic [1:0] {
		fwdReg = 2'b00,
		fwdWb  = 2'b01,
		fwdMem = 2'b10
	} fwdSel;

	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic memWrite;
		logic aluSrc;
		logic regDst;
		logic branch;
		logic jump;
		aluCode aluCtl;
	} ctrlSig;

	typedef struct packed {
		logic stallF;
		logic stallD;
		logic flushD;
		logic flushE;
		logic fwdAD;
		logic fwdBD;
		fwdSel fwdAE;
		fwdSel fwdBE;
	} hazardCtl;

	// data memory request, write lands on the rising edge with we high
	typedef struct packed {
		logic [`MIPS_XLEN-1:0] addr;
		logic [`MIPS_XLEN-1:0] wdata;
		logic we;
	} memReq;

	typedef struct packed {
		instrWord instr;
		logic [`MIPS_XLEN-1:0] pcPlus4;
	} ifIdReg;

	typedef struct packed {
		ctrlSig ctrl;
		logic [`MIPS_XLEN-1:0] srcA;
		logic [`MIPS_XLEN-1:0] srcB;
		logic [`MIPS_XLEN-1:0] signImm;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
	} idExReg;

	typedef struct packed {
		ctrlSig ctrl;
		logic [`MIPS_XLEN-1:0] aluOut;
		logic [`MIPS_XLEN-1:0] writeData;
		logic [4:0] writeReg;
	} exMemReg;

	typedef struct packed {
		ctrlSig ctrl;
		logic [`MIPS_XLEN-1:0] readData;
		logic [`MIPS_XLEN-1:0] aluOut;
		logic [4:0] writeReg;
	} memWbReg;

endpackage

//--- regFile.sv
/*
 * register file, two combinational read ports and one falling-edge write port
 */
`timescale 1ns/10ps
`include "mipsPipe_consts.svh"

module regFile (
	input  logic clk,
	input  logic writeEn,
	input  logic [4:0] readAddrA,
	input  logic [4:0] readAddrB,
	input  logic [4:0] writeAddr,
	input  logic [`MIPS_XLEN-1:0] writeData,
	output logic [`MIPS_XLEN-1:0] readDataA,
	output logic [`MIPS_XLEN-1:0] readDataB
);

	logic [`MIPS_XLEN-1:0] regs [`MIPS_NREGS];

	// write half a cycle into the period so decode reads the new value the same cycle
	always_ff @(negedge clk) begin
		if (writeEn) begin
			regs[writeAddr] <= writeData;
		end
	end

	// register 0 always reads as zero, whatever was written to it
	assign readDataA = (readAddrA != 5'd0) ? regs[readAddrA] : '0;
	assign readDataB = (readAddrB != 5'd0) ? regs[readAddrB] : '0;

	// write enable comes from the write-back register, cleared by the first reset edge
	writeEnKnown: assert property (@(negedge clk) !$isunknown(writeEn))
		else $error("regFile: write enable is unknown");

endmodule

//--- controlUnit.sv
/*
 * main decoder and ALU decoder, instruction word to control struct
 */
`timescale 1ns/10ps
`include "mipsPipe_consts.svh"

module controlUnit (
	input  mipsPkg::instrWord instr,
	output mipsPkg::ctrlSig ctrl
);

	mipsPkg::aluCode aluSel;
	logic functOk;

	// R-type functions this core implements
	assign functOk = instr.rFmt.funct inside {`MIPS_FN_ADD, `MIPS_FN_SUB,
		`MIPS_FN_AND, `MIPS_FN_OR, `MIPS_FN_SLT};

	// ALU decoder
	always_comb begin : aluDecoder
		case (instr.rFmt.op)
			`MIPS_OP_RTYPE: begin
				case (instr.rFmt.funct)
					`MIPS_FN_SUB: aluSel = `MIPS_ALU_SUB;
					`MIPS_FN_AND: aluSel = `MIPS_ALU_AND;
					`MIPS_FN_OR:  aluSel = `MIPS_ALU_OR;
					`MIPS_FN_SLT: aluSel = `MIPS_ALU_SLT;
					default:      aluSel = `MIPS_ALU_ADD;
				endcase
			end
			// beq compares by subtracting
			`MIPS_OP_BEQ: aluSel = `MIPS_ALU_SUB;
			// lw, sw and addi add base and immediate
			default: aluSel = `MIPS_ALU_ADD;
		endcase
	end

	// main decoder, unknown opcodes fall through as a no-op
	always_comb begin : mainDecoder
		ctrl = '0;
		case (instr.iFmt.op)
			`MIPS_OP_RTYPE: begin
				// unsupported funct and the all-zero bubble write nothing
				ctrl.regWrite = functOk;
				ctrl.regDst = 1'b1;
				ctrl.aluCtl = aluSel;
			end
			`MIPS_OP_LW: begin
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.aluCtl = aluSel;
			end
			`MIPS_OP_SW: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.aluCtl = aluSel;
			end
			`MIPS_OP_BEQ: begin
				ctrl.branch = 1'b1;
				ctrl.aluCtl = aluSel;
			end
			`MIPS_OP_ADDI: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.aluCtl = aluSel;
			end
			`MIPS_OP_J: ctrl.jump = 1'b1;
			default: ctrl = '0;
		endcase
	end

	// an R-type other than the nop must carry one of the five supported functions
	unsupportedFunct: assert final ($isunknown(instr) || instr == '0 ||
		instr.rFmt.op != `MIPS_OP_RTYPE || functOk)
		else $error("controlUnit: unsupported funct %h", instr.rFmt.funct);

endmodule

//--- hazardUnit.sv
/*
 * hazard unit with forwarding selects and stall and flush generation
 */
`timescale 1ns/10ps

module hazardUnit (
	input  logic [4:0] rsD,
	input  logic [4:0] rtD,
	input  logic [4:0] rsE,
	input  logic [4:0] rtE,
	input  logic [4:0] writeRegE,
	input  logic [4:0] writeRegM,
	input  logic [4:0] writeRegW,
	input  mipsPkg::ctrlSig ctrlE,
	input  mipsPkg::ctrlSig ctrlM,
	input  mipsPkg::ctrlSig ctrlW,
	input  logic branchD,
	input  logic jumpD,
	input  logic taken,
	output mipsPkg::hazardCtl hz
);

	logic loadStall;
	logic branchStall;
	logic stall;

	// true when a non-zero destination feeds either source
	function automatic logic hits(input logic [4:0] dst, input logic [4:0] a,
		input logic [4:0] b);
		return (dst != 5'd0) && ((dst == a) || (dst == b));
	endfunction

	// memory stage wins over write-back since it holds the younger result
	function automatic mipsPkg::fwdSel pickFwd(input logic [4:0] src);
		if (src != 5'd0 && ctrlM.regWrite && src == writeRegM) begin
			return mipsPkg::fwdMem;
		end
		if (src != 5'd0 && ctrlW.regWrite && src == writeRegW) begin
			return mipsPkg::fwdWb;
		end
		return mipsPkg::fwdReg;
	endfunction

	// a jump's rs and rt bits are target bits so it never waits on a load
	assign loadStall = ctrlE.memToReg && !jumpD && hits(rtE, rsD, rtD);

	// compare operands are produced in execute or still loading in memory
	assign branchStall = branchD &&
		((ctrlE.regWrite && hits(writeRegE, rsD, rtD)) ||
		(ctrlM.memToReg && hits(writeRegM, rsD, rtD)));

	assign stall = loadStall || branchStall;

	always_comb begin
		hz.stallF = stall;
		hz.stallD = stall;
		// a stalled branch has not resolved yet
		hz.flushD = taken && !stall;
		// bubble into execute while decode holds
		hz.flushE = stall;
		// decode compare takes only ALU results since load data is stalled for
		hz.fwdAD = rsD != 5'd0 && ctrlM.regWrite && !ctrlM.memToReg && rsD == writeRegM;
		hz.fwdBD = rtD != 5'd0 && ctrlM.regWrite && !ctrlM.memToReg && rtD == writeRegM;
		hz.fwdAE = pickFwd(rsE);
		hz.fwdBE = pickFwd(rtE);
	end

	// the load-use stall keeps a load in memory from feeding an operand read in execute
	loadNotForwarded: assert final ($isunknown({ctrlM, ctrlE, hz.fwdAE, hz.fwdBE}) ||
		!(ctrlM.memToReg &&
		(((ctrlE.regWrite || ctrlE.memWrite) && hz.fwdAE == mipsPkg::fwdMem) ||
		((ctrlE.regDst || ctrlE.memWrite) && hz.fwdBE == mipsPkg::fwdMem))))
		else $error("hazardUnit: load address forwarded as load data");

endmodule

//--- decodeStage.sv
/*
 * decode stage, register read, compare forwarding, immediate and branch and jump targets
 */
`timescale 1ns/10ps
`include "mipsPipe_consts.svh"

module decodeStage (
	input  logic clk,
	input  mipsPkg::ifIdReg ifId,
	input  logic fwdAD,
	input  logic fwdBD,
	input  logic [`MIPS_XLEN-1:0] aluOutM,
	input  logic [4:0] writeRegW,
	input  logic regWriteW,
	input  logic [`MIPS_XLEN-1:0] resultW,
	output logic [`MIPS_XLEN-1:0] srcA,
	output logic [`MIPS_XLEN-1:0] srcB,
	output logic [`MIPS_XLEN-1:0] signImm,
	output logic [`MIPS_XLEN-1:0] branchTarget,
	output logic [`MIPS_XLEN-1:0] jumpTarget,
	output logic equal
);

	logic [`MIPS_XLEN-1:0] regA;
	logic [`MIPS_XLEN-1:0] regB;

	regFile rf (
		.clk(clk),
		.writeEn(regWriteW),
		.readAddrA(ifId.instr.rFmt.rs),
		.readAddrB(ifId.instr.rFmt.rt),
		.writeAddr(writeRegW),
		.writeData(resultW),
		.readDataA(regA),
		.readDataB(regB)
	);

	// memory-stage result bypasses the register file for the early compare
	assign srcA = fwdAD ? aluOutM : regA;
	assign srcB = fwdBD ? aluOutM : regB;
	assign equal = (srcA == srcB);

	assign signImm = {{(`MIPS_XLEN-16){ifId.instr.iFmt.imm[15]}}, ifId.instr.iFmt.imm};

	// word offset relative to pc+4
	assign branchTarget = ifId.pcPlus4 + {signImm[`MIPS_XLEN-3:0], 2'b00};

	// region bits come from pc+4
	assign jumpTarget = {ifId.pcPlus4[31:28], ifId.instr.jFmt.target, 2'b00};

endmodule

//--- aluUnit.sv
/*
 * 32-bit ALU, logic, add, subtract and signed set-less-than
 */
`timescale 1ns/10ps
`include "mipsPipe_consts.svh"

module aluUnit (
	input  logic [`MIPS_XLEN-1:0] a,
	input  logic [`MIPS_XLEN-1:0] b,
	input  mipsPkg::aluCode op,
	output logic [`MIPS_XLEN-1:0] y
);

	always_comb begin
		case (op)
			`MIPS_ALU_AND:  y = a & b;
			`MIPS_ALU_OR:   y = a | b;
			`MIPS_ALU_ADD:  y = a + b;
			// inverted-b forms, reachable only through the code space
			`MIPS_ALU_ANDN: y = a & ~b;
			`MIPS_ALU_ORN:  y = a | ~b;
			`MIPS_ALU_SUB:  y = a - b;
			// signed compare
			`MIPS_ALU_SLT:  y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			default:        y = '0;
		endcase
	end

endmodule

//--- executeStage.sv
/*
 * execute stage, operand forwarding, immediate select, destination select and ALU
 */
`timescale 1ns/10ps
`include "mipsPipe_consts.svh"

module executeStage (
	input  mipsPkg::idExReg idEx,
	input  mipsPkg::fwdSel fwdAE,
	input  mipsPkg::fwdSel fwdBE,
	input  logic [`MIPS_XLEN-1:0] resultW,
	input  logic [`MIPS_XLEN-1:0] aluOutM,
	output logic [`MIPS_XLEN-1:0] aluOut,
	output logic [`MIPS_XLEN-1:0] writeData,
	output logic [4:0] writeReg
);

	logic [`MIPS_XLEN-1:0] srcA;
	logic [`MIPS_XLEN-1:0] srcB;

	// register value, or a result still in flight
	function automatic logic [`MIPS_XLEN-1:0] pickSrc(input mipsPkg::fwdSel sel,
		input logic [`MIPS_XLEN-1:0] regVal);
		case (sel)
			mipsPkg::fwdWb:  return resultW;
			mipsPkg::fwdMem: return aluOutM;
			default:         return regVal;
		endcase
	endfunction

	assign srcA = pickSrc(fwdAE, idEx.srcA);
	// store data is the forwarded b, before the immediate mux
	assign writeData = pickSrc(fwdBE, idEx.srcB);
	assign srcB = idEx.ctrl.aluSrc ? idEx.signImm : writeData;

	// R-type writes rd, I-type writes rt
	assign writeReg = idEx.ctrl.regDst ? idEx.rd : idEx.rt;

	aluUnit alu (
		.a(srcA),
		.b(srcB),
		.op(idEx.ctrl.aluCtl),
		.y(aluOut)
	);

endmodule

//--- mipsPipe.sv
/*
 * five-stage pipelined core top, PC, next-PC select, pipeline registers,
 * memory-stage wiring and write-back select
 */
`timescale 1ns/10ps
`include "mipsPipe_consts.svh"

module mipsPipe (
	input  logic clk,
	input  logic reset,
	output logic [`MIPS_XLEN-1:0] imemAddr,
	input  mipsPkg::instrWord imemData,
	output mipsPkg::memReq dmemReq,
	input  logic [`MIPS_XLEN-1:0] dmemRdata
);

	logic [`MIPS_XLEN-1:0] pc;
	logic [`MIPS_XLEN-1:0] pcPlus4F;
	logic [`MIPS_XLEN-1:0] pcNext;

	mipsPkg::ifIdReg ifId;
	mipsPkg::idExReg idEx;
	mipsPkg::exMemReg exMem;
	mipsPkg::memWbReg memWb;

	mipsPkg::ctrlSig ctrlD;
	mipsPkg::hazardCtl hz;

	logic [`MIPS_XLEN-1:0] srcAD;
	logic [`MIPS_XLEN-1:0] srcBD;
	logic [`MIPS_XLEN-1:0] signImmD;
	logic [`MIPS_XLEN-1:0] branchTargetD;
	logic [`MIPS_XLEN-1:0] jumpTargetD;
	logic equalD;
	logic taken;

	logic [`MIPS_XLEN-1:0] aluOutE;
	logic [`MIPS_XLEN-1:0] writeDataE;
	logic [4:0] writeRegE;
	logic [`MIPS_XLEN-1:0] resultW;

	// fetch
	assign imemAddr = pc;
	assign pcPlus4F = pc + 32'd4;

	// jump wins over a taken branch and pc+4 is the fallback
	assign taken = ctrlD.jump || (ctrlD.branch && equalD);
	always_comb begin
		if (ctrlD.jump) begin
			pcNext = jumpTargetD;
		end else if (ctrlD.branch && equalD) begin
			pcNext = branchTargetD;
		end else begin
			pcNext = pcPlus4F;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
		end else if (!hz.stallF) begin
			pc <= pcNext;
		end
	end

	// IF/ID register where a flush squashes the instruction fetched behind a taken branch or jump
	always_ff @(posedge clk) begin
		if (reset || hz.flushD) begin
			ifId <= '0;
		end else if (!hz.stallD) begin
			ifId.instr <= imemData;
			ifId.pcPlus4 <= pcPlus4F;
		end
	end

	// decode
	controlUnit ctl (
		.instr(ifId.instr),
		.ctrl(ctrlD)
	);

	decodeStage dec (
		.clk(clk),
		.ifId(ifId),
		.fwdAD(hz.fwdAD),
		.fwdBD(hz.fwdBD),
		.aluOutM(exMem.aluOut),
		.writeRegW(memWb.writeReg),
		.regWriteW(memWb.ctrl.regWrite),
		.resultW(resultW),
		.srcA(srcAD),
		.srcB(srcBD),
		.signImm(signImmD),
		.branchTarget(branchTargetD),
		.jumpTarget(jumpTargetD),
		.equal(equalD)
	);

	hazardUnit hzu (
		.rsD(ifId.instr.rFmt.rs),
		.rtD(ifId.instr.rFmt.rt),
		.rsE(idEx.rs),
		.rtE(idEx.rt),
		.writeRegE(writeRegE),
		.writeRegM(exMem.writeReg),
		.writeRegW(memWb.writeReg),
		.ctrlE(idEx.ctrl),
		.ctrlM(exMem.ctrl),
		.ctrlW(memWb.ctrl),
		.branchD(ctrlD.branch),
		.jumpD(ctrlD.jump),
		.taken(taken),
		.hz(hz)
	);

	// ID/EX register takes a bubble on stall so execute does nothing twice
	always_ff @(posedge clk) begin
		if (reset || hz.flushE) begin
			idEx <= '0;
		end else begin
			idEx.ctrl <= ctrlD;
			idEx.srcA <= srcAD;
			idEx.srcB <= srcBD;
			idEx.signImm <= signImmD;
			idEx.rs <= ifId.instr.rFmt.rs;
			idEx.rt <= ifId.instr.rFmt.rt;
			idEx.rd <= ifId.instr.rFmt.rd;
		end
	end

	// execute
	executeStage exe (
		.idEx(idEx),
		.fwdAE(hz.fwdAE),
		.fwdBE(hz.fwdBE),
		.resultW(resultW),
		.aluOutM(exMem.aluOut),
		.aluOut(aluOutE),
		.writeData(writeDataE),
		.writeReg(writeRegE)
	);

	// EX/MEM
	always_ff @(posedge clk) begin
		if (reset) begin
			exMem <= '0;
		end else begin
			exMem.ctrl <= idEx.ctrl;
			exMem.aluOut <= aluOutE;
			exMem.writeData <= writeDataE;
			exMem.writeReg <= writeRegE;
		end
	end

	// memory stage drives the data memory directly
	assign dmemReq.addr = exMem.aluOut;
	assign dmemReq.wdata = exMem.writeData;
	assign dmemReq.we = exMem.ctrl.memWrite;

	// MEM/WB
	always_ff @(posedge clk) begin
		if (reset) begin
			memWb <= '0;
		end else begin
			memWb.ctrl <= exMem.ctrl;
			memWb.readData <= dmemRdata;
			memWb.aluOut <= exMem.aluOut;
			memWb.writeReg <= exMem.writeReg;
		end
	end

	// write-back
	assign resultW = memWb.ctrl.memToReg ? memWb.readData : memWb.aluOut;

	// the slot squashed behind a resolved branch or jump never writes data memory
	squashBehindTaken: assert property (@(posedge clk) disable iff (reset)
		(taken && !hz.stallD) |=> ##2 !dmemReq.we)
		else $error("mipsPipe: squashed slot behind a taken branch wrote data memory");

endmodule

//--- tbMipsPipe.sv
/*
 * directed testbench for the pipelined core, memory models, program encoders,
 * compare tasks, timeout and the five directed tests
 */
`timescale 1ns/10ps
`include "mipsPipe_consts.svh"

module tbMipsPipe;

	logic clk = 1'b0;
	logic reset;
	logic [`MIPS_XLEN-1:0] imemAddr;
	mipsPkg::instrWord imemData;
	mipsPkg::memReq dmemReq;
	logic [`MIPS_XLEN-1:0] dmemRdata;

	// two word-addressed memories of 1 KB each
	mipsPkg::instrWord imem [256];
	logic [`MIPS_XLEN-1:0] dmem [256];

	mipsPkg::instrWord prog [$];
	mipsPkg::memReq storeLog [$];
	mipsPkg::memReq expLog [$];

	int cycles;
	int cycleLimit;
	logic [31:0] rngState;

	mipsPipe UUT (
		.clk(clk),
		.reset(reset),
		.imemAddr(imemAddr),
		.imemData(imemData),
		.dmemReq(dmemReq),
		.dmemRdata(dmemRdata)
	);

	always #2 clk = ~clk;

	// both memories answer in the same cycle
	assign imemData = imem[imemAddr[9:2]];
	assign dmemRdata = dmem[dmemReq.addr[9:2]];

	// data write on the rising edge and every write goes to the log
	always @(posedge clk) begin
		if (dmemReq.we === 1'b1) begin
			dmem[dmemReq.addr[9:2]] <= dmemReq.wdata;
			storeLog.push_back(dmemReq);
		end
	end

	// prints the verdict and ends the run
	task automatic abortRun();
		$display("Test FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	// limit grows by three cycles per loaded instruction
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycleLimit) begin
			$display("timeout: the program did not reach its final store after %0d cycles",
				cycles);
			abortRun();
		end
	end

	task automatic checkWord(input string name, input logic [`MIPS_XLEN-1:0] got,
		input logic [`MIPS_XLEN-1:0] exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
			abortRun();
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
			abortRun();
		end
	endtask

	task automatic checkReq(input string name, input mipsPkg::memReq got,
		input mipsPkg::memReq exp);
		checkWord({name, ".addr"}, got.addr, exp.addr);
		checkWord({name, ".wdata"}, got.wdata, exp.wdata);
		checkBit({name, ".we"}, got.we, exp.we);
	endtask

	function automatic logic [31:0] nextRandom();
		logic [31:0] x;
		x = rngState;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rngState = x;
		return x;
	endfunction

	function automatic logic [31:0] sext16(input logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	// instruction encoders
	function automatic mipsPkg::instrWord rType(input logic [5:0] funct,
		input logic [4:0] rd, input logic [4:0] rs, input logic [4:0] rt);
		mipsPkg::instrWord w;
		w.rFmt.op = `MIPS_OP_RTYPE;
		w.rFmt.rs = rs;
		w.rFmt.rt = rt;
		w.rFmt.rd = rd;
		w.rFmt.shamt = 5'd0;
		w.rFmt.funct = funct;
		return w;
	endfunction

	function automatic mipsPkg::instrWord iType(input logic [5:0] op,
		input logic [4:0] rs, input logic [4:0] rt, input logic [15:0] imm);
		mipsPkg::instrWord w;
		w.iFmt.op = op;
		w.iFmt.rs = rs;
		w.iFmt.rt = rt;
		w.iFmt.imm = imm;
		return w;
	endfunction

	// target given as a word index into instruction memory
	function automatic mipsPkg::instrWord jumpTo(input int unsigned idx);
		mipsPkg::instrWord w;
		w.jFmt.op = `MIPS_OP_J;
		w.jFmt.target = 26'(idx);
		return w;
	endfunction

	function automatic void expectStore(input logic [31:0] addr, input logic [31:0] data);
		mipsPkg::memReq r;
		r.addr = addr;
		r.wdata = data;
		r.we = 1'b1;
		expLog.push_back(r);
	endfunction

	function automatic logic lastStoreAt(input logic [31:0] addr);
		mipsPkg::memReq last;
		if (storeLog.size() == 0) begin
			return 1'b0;
		end
		last = storeLog[storeLog.size() - 1];
		return last.addr == addr;
	endfunction

	// reset for two edges with the memories reloaded while the core is held
	task automatic startProgram();
		int i;
		@(posedge clk);
		reset <= 1'b1;
		@(posedge clk);
		@(negedge clk);
		for (i = 0; i < 256; i++) begin
			imem[i] = '0;
			dmem[i] = 32'hBAD0_0000 | (i << 2);
		end
		for (i = 0; i < prog.size(); i++) begin
			imem[i] = prog[i];
		end
		storeLog.delete();
		cycleLimit += 3 * prog.size();
		@(posedge clk);
		reset <= 1'b0;
	endtask

	task automatic runToStore(input logic [31:0] doneAddr);
		while (!lastStoreAt(doneAddr)) begin
			@(negedge clk);
		end
	endtask

	task automatic compareLog();
		int i;
		checkWord("storeLog.size", storeLog.size(), expLog.size());
		for (i = 0; i < expLog.size(); i++) begin
			checkReq($sformatf("storeLog[%0d]", i), storeLog[i], expLog[i]);
		end
	endtask

	// fetch starts at 0 and steps by 4 with no store out of reset
	task automatic fetchAfterReset();
		int k;
		prog.delete();
		repeat (4) prog.push_back('0);
		startProgram();
		for (k = 0; k < 3; k++) begin
			@(negedge clk);
			checkWord("imemAddr", imemAddr, k * 4);
			checkBit("dmemReq.we", dmemReq.we, 1'b0);
		end
	endtask

	// dependent ALU ops one and two apart and r7 read three apart through the regfile
	task automatic aluForwarding();
		logic [31:0] r1, r2, r3, r4, r5, r6, r7, r8, r9;
		prog.delete();
		expLog.delete();
		r1 = 32'h0000_1234;
		r2 = sext16(16'hFFFB);
		r3 = r1 + r2;
		r4 = r3 - r1;
		r5 = r4 & r3;
		r6 = r5 | r1;
		r7 = ($signed(r4) < $signed(r6)) ? 32'd1 : 32'd0;
		r8 = r7 + 32'd100;
		r9 = ($signed(r6) < $signed(r4)) ? 32'd1 : 32'd0;
		prog.push_back(iType(`MIPS_OP_ADDI, 5'd0, 5'd1, 16'h1234));
		prog.push_back(iType(`MIPS_OP_ADDI, 5'd0, 5'd2, 16'hFFFB));
		prog.push_back(rType(`MIPS_FN_ADD, 5'd3, 5'd1, 5'd2));
		prog.push_back(iType(`MIPS_OP_SW, 5'd0, 5'd3, 16'h0040));
		prog.push_back(rType(`MIPS_FN_SUB, 5'd4, 5'd3, 5'd1));
		prog.push_back(rType(`MIPS_FN_AND, 5'd5, 5'd4, 5'd3));
		prog.push_back(iType(`MIPS_OP_SW, 5'd0, 5'd4, 16'h0044));
		prog.push_back(rType(`MIPS_FN_OR, 5'd6, 5'd5, 5'd1));
		prog.push_back(rType(`MIPS_FN_SLT, 5'd7, 5'd4, 5'd6));
		prog.push_back(iType(`MIPS_OP_SW, 5'd0, 5'd5, 16'h0048));
		prog.push_back(iType(`MIPS_OP_SW, 5'd0, 5'd6, 16'h004C));
		prog.push_back(iType(`MIPS_OP_ADDI, 5'd7, 5'd8, 16'd100));
		prog.push_back(iType(`MIPS_OP_SW, 5'd0, 5'd7, 16'h0050));
		prog.push_back(iType(`MIPS_OP_SW, 5'd0, 5'd8, 16'h0054));
		prog.push_back(rType(`MIPS_FN_SLT, 5'd9, 5'd6, 5'd4));
		prog.push_back(iType(`MIPS_OP_SW, 5'd0, 5'd9, 16'h0058));
		prog.push_back(jumpTo(prog.size()));
		expectStore(32'h40, r3);
		expectStore(32'h44, r4);
		expectStore(32'h48, r5);
		expectStore(32'h4C, r6);
		expectStore(32'h50, r7);
		expectStore(32'h54, r8);
		expectStore(32'h58, r9);
		startProgram();
		runToStore(32'h58);
		compareLog();
	endtask

	// loaded value used at once by an add and by a store
	task automatic loadUse();
		logic [31:0] val;
		logic [31:0] other;
		prog.delete();
		expLog.delete();
		val = 32'h77;
		other = 32'h300;
		prog.push_back(iType(`MIPS_OP_ADDI, 5'd0, 5'd1, val[15:0]));
		prog.push_back(iType(`MIPS_OP_ADDI, 5'd0, 5'd2, other[15:0]));
		prog.push_back(iType(`MIPS_OP_SW, 5'd0, 5'd1, 16'h0080));
		prog.push_back(iType(`MIPS_OP_LW, 5'd0, 5'd3, 16'h0080));
		prog.push_back(rType(`MIPS_FN_ADD, 5'd4, 5'd3, 5'd2));
		prog.push_back(iType(`MIPS_OP_SW, 5'd0, 5'd4, 16'h0084));
		prog.push_back(iType(`MIPS_OP_LW, 5'd0, 5'd5, 16'h0080));
		prog.push_back(iType(`MIPS_OP_SW, 5'd0, 5'd5, 16'h0088));
		prog.push_back(jumpTo(prog.size()));
		expectStore(32'h80, val);
		expectStore(32'h84, val + other);
		expectStore(32'h88, val);
		startProgram();
		runToStore(32'h88);
		compareLog();
	endtask

	// marker stores sit behind every taken branch and jump
	task automatic branchJump();
		prog.delete();
		expLog.delete();
		prog.push_back(iType(`MIPS_OP_ADDI, 5'd0, 5'd10, 16'h7EAD));
		prog.push_back(iType(`MIPS_OP_ADDI, 5'd0, 5'd1, 16'd5));
		prog.push_back(iType(`MIPS_OP_ADDI, 5'd0, 5'd2, 16'd5));
		// taken with rt from the addi just before
		prog.push_back(iType(`MIPS_OP_BEQ, 5'd1, 5'd2, 16'd1));
		prog.push_back(iType(`MIPS_OP_SW, 5'd0, 5'd10, 16'h00F0));
		prog.push_back(iType(`MIPS_OP_ADDI, 5'd0, 5'd3, 16'd9));
		// not taken as 9 differs from 5
		prog.push_back(iType(`MIPS_OP_BEQ, 5'd3, 5'd1, 16'd1));
		prog.push_back(iType(`MIPS_OP_SW, 5'd0, 5'd3, 16'h00A0));
		prog.push_back(jumpTo(prog.size() + 2));
		prog.push_back(iType(`MIPS_OP_SW, 5'd0, 5'd10, 16'h00F4));
		prog.push_back(iType(`MIPS_OP_SW, 5'd0, 5'd1, 16'h00A4));
		// always taken without a hazard
		prog.push_back(iType(`MIPS_OP_BEQ, 5'd0, 5'd0, 16'd1));
		prog.push_back(iType(`MIPS_OP_SW, 5'd0, 5'd10, 16'h00F8));
		prog.push_back(iType(`MIPS_OP_SW, 5'd0, 5'd2, 16'h00A8));
		prog.push_back(jumpTo(prog.size()));
		expectStore(32'hA0, 32'd9);
		expectStore(32'hA4, 32'd5);
		expectStore(32'hA8, 32'd5);
		startProgram();
		runToStore(32'hA8);
		compareLog();
	endtask

	// twelve random addi into r1 with a store after every fourth
	task automatic randomChain();
		logic [31:0] sum;
		logic [31:0] rnd;
		logic [15:0] imm;
		logic [15:0] offset;
		int k;
		prog.delete();
		expLog.delete();
		sum = 32'd0;
		prog.push_back(iType(`MIPS_OP_ADDI, 5'd0, 5'd2, 16'h0100));
		prog.push_back(iType(`MIPS_OP_ADDI, 5'd0, 5'd1, 16'd0));
		for (k = 0; k < 12; k++) begin
			rnd = nextRandom();
			imm = rnd[15:0];
			sum = sum + sext16(imm);
			prog.push_back(iType(`MIPS_OP_ADDI, 5'd1, 5'd1, imm));
			if (k % 4 == 3) begin
				offset = 16'((k / 4) * 8);
				prog.push_back(iType(`MIPS_OP_SW, 5'd2, 5'd1, offset));
				expectStore(32'h100 + offset, sum);
			end
		end
		prog.push_back(jumpTo(prog.size()));
		startProgram();
		runToStore(32'h110);
		compareLog();
	endtask

	initial begin
		reset = 1'b1;
		cycles = 0;
		cycleLimit = 100;
		rngState = 32'hd9c5_e4a5;
		fetchAfterReset();
		aluForwarding();
		loadUse();
		branchJump();
		randomChain();
		$display("Test OK");
		$finish;
	end

endmodule

//--- mipsPipe.f
+incdir+.
mipsPkg.sv
regFile.sv
controlUnit.sv
hazardUnit.sv
decodeStage.sv
aluUnit.sv
executeStage.sv
mipsPipe.sv
tbMipsPipe.sv

//--- Bender.yml
package:
  name: mipsPipe

# mipsPipe_consts.svh is picked up through the include directory
export_include_dirs:
  - .

sources:
  - mipsPkg.sv
  - regFile.sv
  - controlUnit.sv
  - hazardUnit.sv
  - decodeStage.sv
  - aluUnit.sv
  - executeStage.sv
  - mipsPipe.sv
  - target: test
    files:
      - tbMipsPipe.sv
